/* source/mm_pkg.sv */
package mm_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int MAT_MUL_SIZE = 8;
  localparam int DWIDTH       = 8;
  localparam int AWIDTH       = 10;
  localparam int STRIDE_WIDTH = 16;
  localparam int REG_DWIDTH   = 32;
  localparam int REG_AWIDTH   = 8;
  // Bits to index a lane, a row or a k step
  localparam int IDX_WIDTH    = $clog2(MAT_MUL_SIZE);

  typedef logic [DWIDTH-1:0]              elem_t;
  typedef logic [MAT_MUL_SIZE*DWIDTH-1:0] row_t;
  typedef logic [AWIDTH-1:0]              addr_t;
  typedef logic [STRIDE_WIDTH-1:0]        stride_t;
  typedef logic [MAT_MUL_SIZE-1:0]        lane_mask_t;
  typedef logic [REG_DWIDTH-1:0]          reg_data_t;
  typedef logic [REG_AWIDTH-1:0]          reg_addr_t;
  typedef logic [IDX_WIDTH-1:0]           idx_t;

  localparam idx_t IDX_LAST = idx_t'(MAT_MUL_SIZE - 1);

  //////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////
  localparam reg_addr_t REG_CTRL_ADDR = 8'h04;
  localparam reg_addr_t REG_A_ADDR    = 8'h0E;
  localparam reg_addr_t REG_B_ADDR    = 8'h12;
  localparam reg_addr_t REG_C_ADDR    = 8'h16;
  localparam reg_addr_t REG_A_STRIDE  = 8'h28;
  localparam reg_addr_t REG_B_STRIDE  = 8'h32;
  localparam reg_addr_t REG_C_STRIDE  = 8'h03;

  // Host bank select codes
  localparam logic [7:0] BANK_A = 8'd0;
  localparam logic [7:0] BANK_B = 8'd1;
  localparam logic [7:0] BANK_C = 8'd2;

  localparam stride_t STRIDE_RESET = stride_t'(MAT_MUL_SIZE);

endpackage

/* source/apb_config_regs.sv */
`timescale 1ns/1ps

module apb_config_regs (
  input  logic              clk,
  input  logic              PRESETn,
  input  logic              PSEL,
  input  logic              PENABLE,
  input  logic              PWRITE,
  input  mm_pkg::reg_addr_t PADDR,
  input  mm_pkg::reg_data_t PWDATA,
  output mm_pkg::reg_data_t PRDATA,
  output logic              PREADY,
  input  logic              busy,
  input  logic              done,
  output logic              start,
  output logic              clear_done,
  output mm_pkg::addr_t     base_a,
  output mm_pkg::addr_t     base_b,
  output mm_pkg::addr_t     base_c,
  output mm_pkg::stride_t   stride_a,
  output mm_pkg::stride_t   stride_b,
  output mm_pkg::stride_t   stride_c
);

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_W_ENABLE,
    APB_R_ENABLE
  } apb_state_t;

  apb_state_t        state;
  mm_pkg::reg_data_t reg_dummy;
  mm_pkg::reg_data_t rd_mux;

  // Readback mux with narrow registers zero extended
  always_comb begin
    case (PADDR)
      mm_pkg::REG_CTRL_ADDR: rd_mux = {done, {(mm_pkg::REG_DWIDTH-2){1'b0}}, busy};
      mm_pkg::REG_A_ADDR:    rd_mux = mm_pkg::reg_data_t'(base_a);
      mm_pkg::REG_B_ADDR:    rd_mux = mm_pkg::reg_data_t'(base_b);
      mm_pkg::REG_C_ADDR:    rd_mux = mm_pkg::reg_data_t'(base_c);
      mm_pkg::REG_A_STRIDE:  rd_mux = mm_pkg::reg_data_t'(stride_a);
      mm_pkg::REG_B_STRIDE:  rd_mux = mm_pkg::reg_data_t'(stride_b);
      mm_pkg::REG_C_STRIDE:  rd_mux = mm_pkg::reg_data_t'(stride_c);
      default:               rd_mux = reg_dummy;
    endcase
  end

  //////////////////////////////////////////////////
  // APB slave FSM and register file
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state      <= APB_IDLE;
      PRDATA     <= '0;
      PREADY     <= 1'b0;
      start      <= 1'b0;
      clear_done <= 1'b0;
      base_a     <= '0;
      base_b     <= '0;
      base_c     <= '0;
      stride_a   <= mm_pkg::STRIDE_RESET;
      stride_b   <= mm_pkg::STRIDE_RESET;
      stride_c   <= mm_pkg::STRIDE_RESET;
      reg_dummy  <= '0;
    end else begin
      case (state)
        APB_IDLE: begin
          PRDATA <= '0;
          PREADY <= 1'b0;
          // Setup phase only
          if (PSEL && !PENABLE) begin
            state <= PWRITE ? APB_W_ENABLE : APB_R_ENABLE;
          end
        end
        APB_W_ENABLE: begin
          if (!PSEL) begin
            state <= APB_IDLE;
          end else if (PENABLE) begin
            case (PADDR)
              mm_pkg::REG_CTRL_ADDR: begin
                start      <= PWDATA[0];
                clear_done <= PWDATA[mm_pkg::REG_DWIDTH-1];
              end
              mm_pkg::REG_A_ADDR:   base_a   <= PWDATA[mm_pkg::AWIDTH-1:0];
              mm_pkg::REG_B_ADDR:   base_b   <= PWDATA[mm_pkg::AWIDTH-1:0];
              mm_pkg::REG_C_ADDR:   base_c   <= PWDATA[mm_pkg::AWIDTH-1:0];
              mm_pkg::REG_A_STRIDE: stride_a <= PWDATA[mm_pkg::STRIDE_WIDTH-1:0];
              mm_pkg::REG_B_STRIDE: stride_b <= PWDATA[mm_pkg::STRIDE_WIDTH-1:0];
              mm_pkg::REG_C_STRIDE: stride_c <= PWDATA[mm_pkg::STRIDE_WIDTH-1:0];
              default:              reg_dummy <= PWDATA;
            endcase
            PREADY <= 1'b1;
            state  <= APB_IDLE;
          end
        end
        APB_R_ENABLE: begin
          if (!PSEL) begin
            state <= APB_IDLE;
          end else if (PENABLE) begin
            PRDATA <= rd_mux;
            PREADY <= 1'b1;
            state  <= APB_IDLE;
          end
        end
        default: state <= APB_IDLE;
      endcase
    end
  end

  // One ready cycle per transfer
  a_pready_single: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |=> !PREADY);

endmodule

/* source/matmul_ctrl.sv */
`timescale 1ns/1ps

module matmul_ctrl (
  input  logic clk,
  input  logic PRESETn,
  input  logic start,
  input  logic clear_done,
  input  logic done_pulse,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LAUNCH,
    ST_BUSY,
    ST_DONE
  } ctrl_state_t;

  ctrl_state_t state;

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state <= ST_IDLE;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_LAUNCH;
          end
        end
        ST_LAUNCH: begin
          state <= ST_BUSY;
          busy  <= 1'b1;
        end
        ST_BUSY: begin
          // Sequencer signals the last C row is written
          if (done_pulse) begin
            state <= ST_DONE;
            busy  <= 1'b0;
            done  <= 1'b1;
          end
        end
        ST_DONE: begin
          if (clear_done) begin
            state <= ST_IDLE;
            done  <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_busy_done_excl: assert property (@(posedge clk) disable iff (!PRESETn)
    !(busy && done));

endmodule

/* source/operand_sequencer.sv */
`timescale 1ns/1ps

module operand_sequencer (
  input  logic               clk,
  input  logic               PRESETn,
  input  logic               busy,
  input  mm_pkg::addr_t      base_a,
  input  mm_pkg::addr_t      base_b,
  input  mm_pkg::addr_t      base_c,
  input  mm_pkg::stride_t    stride_a,
  input  mm_pkg::stride_t    stride_b,
  input  mm_pkg::stride_t    stride_c,
  output mm_pkg::addr_t      a_addr,
  output mm_pkg::addr_t      b_addr,
  output mm_pkg::addr_t      c_addr,
  output mm_pkg::idx_t       k_sel,
  output logic               acc_first,
  output logic               acc_en,
  output mm_pkg::lane_mask_t c_we,
  output logic               done_pulse
);

  mm_pkg::idx_t row_cnt;
  mm_pkg::idx_t k_cnt;
  logic         issued_all;
  logic         issue;
  logic         k_last;
  logic         row_last;
  // Data phase and write phase pipeline
  logic         row_end_q;
  logic         wr_q;
  mm_pkg::idx_t row_q;
  mm_pkg::idx_t row_q2;

  assign issue    = busy && !issued_all;
  assign k_last   = (k_cnt == mm_pkg::IDX_LAST);
  assign row_last = (row_cnt == mm_pkg::IDX_LAST);

  // Strided addresses wrap to the memory size
  assign a_addr = mm_pkg::addr_t'(base_a + row_cnt * stride_a);
  assign b_addr = mm_pkg::addr_t'(base_b + k_cnt * stride_b);
  assign c_addr = mm_pkg::addr_t'(base_c + row_q2 * stride_c);
  assign c_we   = {mm_pkg::MAT_MUL_SIZE{wr_q}};

  //////////////////////////////////////////////////
  // Row and k counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn || !busy) begin
      row_cnt    <= '0;
      k_cnt      <= '0;
      issued_all <= 1'b0;
    end else if (issue) begin
      k_cnt <= k_cnt + mm_pkg::idx_t'(1);
      if (k_last) begin
        row_cnt <= row_cnt + mm_pkg::idx_t'(1);
        if (row_last) begin
          issued_all <= 1'b1;
        end
      end
    end
  end

  // Strobes follow the read data by one cycle, the C write by two
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      acc_en     <= 1'b0;
      acc_first  <= 1'b0;
      row_end_q  <= 1'b0;
      wr_q       <= 1'b0;
      done_pulse <= 1'b0;
    end else begin
      acc_en     <= issue;
      acc_first  <= issue && (k_cnt == '0);
      row_end_q  <= issue && k_last;
      wr_q       <= row_end_q;
      done_pulse <= wr_q && (row_q2 == mm_pkg::IDX_LAST);
    end
  end

  always_ff @(posedge clk) begin
    k_sel  <= k_cnt;
    row_q  <= row_cnt;
    row_q2 <= row_q;
  end

  a_cwe_in_run: assert property (@(posedge clk) disable iff (!PRESETn)
    (c_we != '0) |-> busy);

endmodule

/* source/matrix_ram.sv */
`timescale 1ns/1ps

module matrix_ram (
  input  logic               clk,
  input  mm_pkg::addr_t      addr0,
  input  mm_pkg::row_t       d0,
  input  mm_pkg::lane_mask_t we0,
  output mm_pkg::row_t       q0,
  input  mm_pkg::addr_t      addr1,
  input  mm_pkg::row_t       d1,
  input  mm_pkg::lane_mask_t we1,
  output mm_pkg::row_t       q1
);

  // One element per byte address
  mm_pkg::elem_t mem [0:(1 << mm_pkg::AWIDTH)-1];

  //////////////////////////////////////////////////
  // Per lane write and registered read
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int j = 0; j < mm_pkg::MAT_MUL_SIZE; j++) begin
      if (we0[j]) begin
        mem[mm_pkg::addr_t'(addr0 + j)] <= d0[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH];
      end
      // Port 1 wins on a same address collision
      if (we1[j]) begin
        mem[mm_pkg::addr_t'(addr1 + j)] <= d1[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH];
      end
      q0[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH] <= mem[mm_pkg::addr_t'(addr0 + j)];
      q1[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH] <= mem[mm_pkg::addr_t'(addr1 + j)];
    end
  end

endmodule

/* source/row_mac.sv */
`timescale 1ns/1ps

module row_mac (
  input  logic         clk,
  input  logic         PRESETn,
  input  mm_pkg::row_t a_row,
  input  mm_pkg::row_t b_row,
  input  mm_pkg::idx_t k_sel,
  input  logic         acc_first,
  input  logic         acc_en,
  output mm_pkg::row_t c_row
);

  mm_pkg::elem_t a_elem;
  mm_pkg::row_t  prod;

  // Element k of the A row against every lane of B row k
  always_comb begin
    a_elem = a_row[k_sel*mm_pkg::DWIDTH +: mm_pkg::DWIDTH];
    for (int j = 0; j < mm_pkg::MAT_MUL_SIZE; j++) begin
      prod[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH] =
        mm_pkg::elem_t'(a_elem * b_row[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH]);
    end
  end

  //////////////////////////////////////////////////
  // Lane accumulators that wrap at 8 bits
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      c_row <= '0;
    end else if (acc_en) begin
      for (int j = 0; j < mm_pkg::MAT_MUL_SIZE; j++) begin
        if (acc_first) begin
          c_row[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH] <=
            prod[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH];
        end else begin
          c_row[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH] <=
            mm_pkg::elem_t'(c_row[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH]
                            + prod[j*mm_pkg::DWIDTH +: mm_pkg::DWIDTH]);
        end
      end
    end
  end

endmodule

/* source/matmul_top.sv */
`timescale 1ns/1ps

module matmul_top (
  input  logic               clk,
  input  logic               PRESETn,
  input  logic               PSEL,
  input  logic               PENABLE,
  input  logic               PWRITE,
  input  mm_pkg::reg_addr_t  PADDR,
  input  mm_pkg::reg_data_t  PWDATA,
  output mm_pkg::reg_data_t  PRDATA,
  output logic               PREADY,
  input  logic [7:0]         bram_select,
  input  mm_pkg::addr_t      bram_addr_ext,
  input  mm_pkg::row_t       bram_wdata_ext,
  input  mm_pkg::lane_mask_t bram_we_ext,
  output mm_pkg::row_t       bram_rdata_ext
);

  logic               start;
  logic               clear_done;
  logic               busy;
  logic               done;
  logic               done_pulse;
  mm_pkg::addr_t      base_a;
  mm_pkg::addr_t      base_b;
  mm_pkg::addr_t      base_c;
  mm_pkg::stride_t    stride_a;
  mm_pkg::stride_t    stride_b;
  mm_pkg::stride_t    stride_c;
  mm_pkg::addr_t      a_addr;
  mm_pkg::addr_t      b_addr;
  mm_pkg::addr_t      c_addr;
  mm_pkg::idx_t       k_sel;
  logic               acc_first;
  logic               acc_en;
  mm_pkg::lane_mask_t c_we;
  mm_pkg::row_t       a_row;
  mm_pkg::row_t       b_row;
  mm_pkg::row_t       c_row;
  mm_pkg::lane_mask_t host_we_a;
  mm_pkg::lane_mask_t host_we_b;
  mm_pkg::lane_mask_t host_we_c;
  mm_pkg::row_t       host_q_a;
  mm_pkg::row_t       host_q_b;
  mm_pkg::row_t       host_q_c;
  // Select that goes with the read data in flight
  logic [7:0]         sel_q;

  apb_config_regs u_apb_config_regs (
    .clk(clk), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .busy(busy), .done(done), .start(start), .clear_done(clear_done),
    .base_a(base_a), .base_b(base_b), .base_c(base_c),
    .stride_a(stride_a), .stride_b(stride_b), .stride_c(stride_c)
  );

  matmul_ctrl u_matmul_ctrl (
    .clk(clk), .PRESETn(PRESETn), .start(start), .clear_done(clear_done),
    .done_pulse(done_pulse), .busy(busy), .done(done)
  );

  operand_sequencer u_operand_sequencer (
    .clk(clk), .PRESETn(PRESETn), .busy(busy),
    .base_a(base_a), .base_b(base_b), .base_c(base_c),
    .stride_a(stride_a), .stride_b(stride_b), .stride_c(stride_c),
    .a_addr(a_addr), .b_addr(b_addr), .c_addr(c_addr), .k_sel(k_sel),
    .acc_first(acc_first), .acc_en(acc_en), .c_we(c_we), .done_pulse(done_pulse)
  );

  row_mac u_row_mac (
    .clk(clk), .PRESETn(PRESETn), .a_row(a_row), .b_row(b_row), .k_sel(k_sel),
    .acc_first(acc_first), .acc_en(acc_en), .c_row(c_row)
  );

  //////////////////////////////////////////////////
  // Matrix memories with the engine on port 0
  //////////////////////////////////////////////////
  assign host_we_a = (bram_select == mm_pkg::BANK_A) ? bram_we_ext : '0;
  assign host_we_b = (bram_select == mm_pkg::BANK_B) ? bram_we_ext : '0;
  assign host_we_c = (bram_select == mm_pkg::BANK_C) ? bram_we_ext : '0;

  matrix_ram u_mem_a (
    .clk(clk), .addr0(a_addr), .d0('0), .we0('0), .q0(a_row),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(host_we_a), .q1(host_q_a)
  );

  matrix_ram u_mem_b (
    .clk(clk), .addr0(b_addr), .d0('0), .we0('0), .q0(b_row),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(host_we_b), .q1(host_q_b)
  );

  matrix_ram u_mem_c (
    .clk(clk), .addr0(c_addr), .d0(c_row), .we0(c_we), .q0(),
    .addr1(bram_addr_ext), .d1(bram_wdata_ext), .we1(host_we_c), .q1(host_q_c)
  );

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      sel_q <= '0;
    end else begin
      sel_q <= bram_select;
    end
  end

  // Invalid select reads zero
  always_comb begin
    case (sel_q)
      mm_pkg::BANK_A: bram_rdata_ext = host_q_a;
      mm_pkg::BANK_B: bram_rdata_ext = host_q_b;
      mm_pkg::BANK_C: bram_rdata_ext = host_q_c;
      default:        bram_rdata_ext = '0;
    endcase
  end

endmodule

/* testbench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// APB master
//////////////////////////////////////////////////
task automatic apb_transfer(input logic write, input mm_pkg::reg_addr_t addr,
                            input mm_pkg::reg_data_t wdata,
                            output mm_pkg::reg_data_t rdata);
  int waits;
  waits = 0;
  @(posedge clk);
  #1;
  // Setup phase
  PSEL    = 1'b1;
  PENABLE = 1'b0;
  PWRITE  = write;
  PADDR   = addr;
  PWDATA  = wdata;
  @(posedge clk);
  #1;
  PENABLE = 1'b1;
  // Hold the access phase until the slave answers
  do begin
    @(posedge clk);
    #1;
    waits++;
  end while (!PREADY && waits < APB_MAX_WAIT);
  rdata = PRDATA;
  assert (PREADY) else begin
    $display("%s: APB transfer to 0x%h never got PREADY", test_name, addr);
    error_count++;
  end
  PSEL    = 1'b0;
  PENABLE = 1'b0;
  @(posedge clk);
  #1;
  assert (!PREADY) else begin
    $display("%s: PREADY stayed high after the transfer to 0x%h", test_name, addr);
    error_count++;
  end
endtask

task automatic apb_write(input mm_pkg::reg_addr_t addr, input mm_pkg::reg_data_t data);
  mm_pkg::reg_data_t unused;
  apb_transfer(1'b1, addr, data, unused);
endtask

task automatic apb_read(input mm_pkg::reg_addr_t addr, output mm_pkg::reg_data_t data);
  apb_transfer(1'b0, addr, '0, data);
endtask

//////////////////////////////////////////////////
// Host memory port
//////////////////////////////////////////////////
task automatic mem_write_row(input logic [7:0] sel, input mm_pkg::addr_t addr,
                             input mm_pkg::row_t row);
  @(posedge clk);
  #1;
  bram_select    = sel;
  bram_addr_ext  = addr;
  bram_wdata_ext = row;
  bram_we_ext    = '1;
  @(posedge clk);
  #1;
  bram_we_ext = '0;
endtask

// Read data comes back one cycle after the address
task automatic mem_read_row(input logic [7:0] sel, input mm_pkg::addr_t addr,
                            output mm_pkg::row_t row);
  @(posedge clk);
  #1;
  bram_select   = sel;
  bram_addr_ext = addr;
  bram_we_ext   = '0;
  @(posedge clk);
  #1;
  row = bram_rdata_ext;
endtask

`endif

/* testbench/tb_matmul_top.sv */
`timescale 1ns/1ps

module tb_matmul_top;

  localparam int N               = mm_pkg::MAT_MUL_SIZE;
  localparam int NUM_TESTS       = 6;
  localparam int CLK_PERIOD      = 100;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (N * N + 40) * 4;
  localparam int APB_MAX_WAIT    = 16;
  localparam int DONE_MAX_POLLS  = N * N;
  localparam mm_pkg::reg_data_t BASE_MASK   = (1 << mm_pkg::AWIDTH) - 1;
  localparam mm_pkg::reg_data_t STRIDE_MASK = (1 << mm_pkg::STRIDE_WIDTH) - 1;
  localparam mm_pkg::reg_data_t CTRL_START  = 32'h0000_0001;
  localparam mm_pkg::reg_data_t CTRL_CLEAR  = 32'h8000_0000;
  localparam mm_pkg::reg_addr_t UNMAPPED    = 8'h40;
  // Layout for the strided runs
  localparam int S_BASE_A   = 100;
  localparam int S_STRIDE_A = 12;
  localparam int S_BASE_B   = 300;
  localparam int S_STRIDE_B = 10;
  localparam int S_BASE_C   = 520;
  localparam int S_STRIDE_C = 9;

  logic               clk;
  logic               PRESETn;
  logic               PSEL;
  logic               PENABLE;
  logic               PWRITE;
  mm_pkg::reg_addr_t  PADDR;
  mm_pkg::reg_data_t  PWDATA;
  mm_pkg::reg_data_t  PRDATA;
  logic               PREADY;
  logic [7:0]         bram_select;
  mm_pkg::addr_t      bram_addr_ext;
  mm_pkg::row_t       bram_wdata_ext;
  mm_pkg::lane_mask_t bram_we_ext;
  mm_pkg::row_t       bram_rdata_ext;

  int         error_count;
  int         errors_at_start;
  int         tests_run;
  int         tests_failed;
  string      test_name;
  logic [7:0] a_m [N][N];
  logic [7:0] b_m [N][N];

  matmul_top u_dut (
    .clk(clk), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .bram_select(bram_select), .bram_addr_ext(bram_addr_ext),
    .bram_wdata_ext(bram_wdata_ext), .bram_we_ext(bram_we_ext),
    .bram_rdata_ext(bram_rdata_ext)
  );

  `include "tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Protocol and status checks
  //////////////////////////////////////////////////
  a_reset_idle: assert property (@(posedge clk) $rose(PRESETn) |-> (!PREADY && PRDATA == '0))
    else begin
      $display("%s: APB outputs not idle after reset", test_name);
      error_count++;
    end

  a_ready_pulse: assert property (@(posedge clk) disable iff (!PRESETn) PREADY |=> !PREADY)
    else begin
      $display("%s: PREADY high for more than one cycle", test_name);
      error_count++;
    end

  a_rdata_quiet: assert property (@(posedge clk) disable iff (!PRESETn)
    !PREADY |-> (PRDATA == '0))
    else begin
      $display("%s: PRDATA not zero outside a ready cycle", test_name);
      error_count++;
    end

  a_status_excl: assert property (@(posedge clk) disable iff (!PRESETn)
    (PREADY && PADDR == mm_pkg::REG_CTRL_ADDR) |-> !(PRDATA[31] && PRDATA[0]))
    else begin
      $display("%s: status shows busy and done together", test_name);
      error_count++;
    end

  task automatic expect_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
    assert (act === exp) else begin
      $display("Error %s: %s expected 0x%h, actual 0x%h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    int n;
    n = error_count - errors_at_start;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("Test %-18s %s (%0d errors)", test_name, (n == 0) ? "PASS" : "FAIL", n);
  endtask

  // C = A x B with every sum wrapped to 8 bits
  function automatic mm_pkg::row_t expected_c_row(input int i);
    logic [7:0]   acc;
    mm_pkg::row_t r;
    for (int j = 0; j < N; j++) begin
      acc = '0;
      for (int k = 0; k < N; k++) begin
        acc = acc + a_m[i][k] * b_m[k][j];
      end
      r[j*8 +: 8] = acc;
    end
    return r;
  endfunction

  task automatic load_matrices(input int ba, input int sa, input int bb, input int sb);
    mm_pkg::row_t ra;
    mm_pkg::row_t rb;
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        a_m[i][k]   = $urandom % 256;
        b_m[i][k]   = $urandom % 256;
        ra[k*8 +: 8] = a_m[i][k];
        rb[k*8 +: 8] = b_m[i][k];
      end
      mem_write_row(mm_pkg::BANK_A, mm_pkg::addr_t'(ba + i * sa), ra);
      mem_write_row(mm_pkg::BANK_B, mm_pkg::addr_t'(bb + i * sb), rb);
    end
  endtask

  // Start a run, then poll status until done
  task automatic run_matmul();
    mm_pkg::reg_data_t status;
    bit                seen_busy;
    int                polls;
    seen_busy = 1'b0;
    polls     = 0;
    apb_write(mm_pkg::REG_CTRL_ADDR, CTRL_START);
    do begin
      apb_read(mm_pkg::REG_CTRL_ADDR, status);
      if (status[0]) begin
        seen_busy = 1'b1;
      end
      polls++;
    end while (!status[31] && polls < DONE_MAX_POLLS);
    assert (seen_busy) else begin
      $display("%s: status never showed busy during the run", test_name);
      error_count++;
    end
    expect_value("status at end of run", CTRL_CLEAR, status);
  endtask

  task automatic check_c(input int bc, input int sc);
    mm_pkg::row_t row;
    for (int i = 0; i < N; i++) begin
      mem_read_row(mm_pkg::BANK_C, mm_pkg::addr_t'(bc + i * sc), row);
      expect_value($sformatf("C row %0d", i), expected_c_row(i), row);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    mm_pkg::reg_data_t    rd;
    mm_pkg::reg_data_t    wr;
    mm_pkg::row_t         row;
    mm_pkg::row_t         bank_rows [3];
    mm_pkg::row_t         marker;
    mm_pkg::reg_addr_t    cfg_addr [6];
    mm_pkg::reg_data_t    cfg_mask [6];
    void'($urandom(18564));
    cfg_addr = '{mm_pkg::REG_A_ADDR, mm_pkg::REG_B_ADDR, mm_pkg::REG_C_ADDR,
                 mm_pkg::REG_A_STRIDE, mm_pkg::REG_B_STRIDE, mm_pkg::REG_C_STRIDE};
    cfg_mask = '{BASE_MASK, BASE_MASK, BASE_MASK, STRIDE_MASK, STRIDE_MASK, STRIDE_MASK};
    error_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_name      = "reset";
    PRESETn        = 1'b0;
    PSEL           = 1'b0;
    PENABLE        = 1'b0;
    PWRITE         = 1'b0;
    PADDR          = '0;
    PWDATA         = '0;
    bram_select    = '0;
    bram_addr_ext  = '0;
    bram_wdata_ext = '0;
    bram_we_ext    = '0;
    repeat (8) @(posedge clk);
    #1;
    PRESETn = 1'b1;

    begin_test("reset_values");
    expect_value("PREADY", 1'b0, PREADY);
    apb_read(mm_pkg::REG_CTRL_ADDR, rd);
    expect_value("status", 0, rd);
    for (int r = 0; r < 6; r++) begin
      apb_read(cfg_addr[r], rd);
      expect_value($sformatf("reg 0x%h", cfg_addr[r]), (r < 3) ? 0 : N, rd);
    end
    end_test();

    begin_test("register_readback");
    for (int r = 0; r < 6; r++) begin
      wr = $urandom;
      apb_write(cfg_addr[r], wr);
      apb_read(cfg_addr[r], rd);
      expect_value($sformatf("reg 0x%h", cfg_addr[r]), wr & cfg_mask[r], rd);
    end
    wr = $urandom;
    apb_write(UNMAPPED, wr);
    apb_read(UNMAPPED, rd);
    expect_value("unmapped register", wr, rd);
    // Back to the reset layout for the default run
    for (int r = 0; r < 6; r++) begin
      apb_write(cfg_addr[r], (r < 3) ? 0 : N);
    end
    end_test();

    begin_test("host_banks");
    for (int b = 0; b < 3; b++) begin
      bank_rows[b] = {$urandom, $urandom};
      mem_write_row(8'(b), 10'd700, bank_rows[b]);
    end
    for (int b = 0; b < 3; b++) begin
      mem_read_row(8'(b), 10'd700, row);
      expect_value($sformatf("bank %0d row", b), bank_rows[b], row);
    end
    mem_write_row(8'd3, 10'd700, {$urandom, $urandom});
    mem_read_row(8'd3, 10'd700, row);
    expect_value("invalid select read", 0, row);
    for (int b = 0; b < 3; b++) begin
      mem_read_row(8'(b), 10'd700, row);
      expect_value($sformatf("bank %0d after invalid write", b), bank_rows[b], row);
    end
    end_test();

    begin_test("default_run");
    load_matrices(0, N, 0, N);
    run_matmul();
    check_c(0, N);
    end_test();

    begin_test("strided_run");
    apb_write(mm_pkg::REG_CTRL_ADDR, CTRL_CLEAR);
    apb_write(mm_pkg::REG_A_ADDR, S_BASE_A);
    apb_write(mm_pkg::REG_B_ADDR, S_BASE_B);
    apb_write(mm_pkg::REG_C_ADDR, S_BASE_C);
    apb_write(mm_pkg::REG_A_STRIDE, S_STRIDE_A);
    apb_write(mm_pkg::REG_B_STRIDE, S_STRIDE_B);
    apb_write(mm_pkg::REG_C_STRIDE, S_STRIDE_C);
    marker = {$urandom, $urandom};
    mem_write_row(mm_pkg::BANK_C, S_BASE_C + (N - 1) * S_STRIDE_C + N, marker);
    load_matrices(S_BASE_A, S_STRIDE_A, S_BASE_B, S_STRIDE_B);
    run_matmul();
    check_c(S_BASE_C, S_STRIDE_C);
    mem_read_row(mm_pkg::BANK_C, S_BASE_C + (N - 1) * S_STRIDE_C + N, row);
    expect_value("marker row", marker, row);
    end_test();

    begin_test("clear_and_rerun");
    apb_write(mm_pkg::REG_CTRL_ADDR, CTRL_CLEAR);
    apb_read(mm_pkg::REG_CTRL_ADDR, rd);
    expect_value("status after clear", 0, rd);
    load_matrices(S_BASE_A, S_STRIDE_A, S_BASE_B, S_STRIDE_B);
    run_matmul();
    check_c(S_BASE_C, S_STRIDE_C);
    end_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+testbench
source/mm_pkg.sv
source/apb_config_regs.sv
source/matmul_ctrl.sv
source/operand_sequencer.sv
source/matrix_ram.sv
source/row_mac.sv
source/matmul_top.sv
testbench/tb_matmul_top.sv

/* Bender.yml */
package:
  name: matmul_accel

sources:
  - files:
      - source/mm_pkg.sv
      - source/apb_config_regs.sv
      - source/matmul_ctrl.sv
      - source/operand_sequencer.sv
      - source/matrix_ram.sv
      - source/row_mac.sv
      - source/matmul_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_matmul_top.sv
